/* Bender.yml */
package:
  name: pcs_rx_lane

sources:
  - pcs_format_pkg.sv
  - pcs_rx_cfg_pkg.sv
  - pcs_block_if.sv
  - pcs_sh_decoder.sv
  - pcs_descrambler.sv
  - pcs_block_counter.sv
  - pcs_rx_lane.sv
  - target: test
    files:
      - pcs_rx_lane_asserts.sv
      - pcs_rx_monitor.sv
      - tb_pcs_rx_lane.sv

/* pcs_block_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module pcs_block_counter (
    input  wire                                          i_clock,
    input  wire                                          i_rst_n,

    pcs_block_if.sink                                    s_in,

    output logic                                         o_valid,
    input  wire                                          i_ready,
    output logic [pcs_format_pkg::NB_DATA_RAW-1:0]       o_data,
    output logic                                         o_ctrl,

    output logic [pcs_rx_cfg_pkg::NB_BLOCK_COUNTER-1:0]  o_n_data,
    output logic [pcs_rx_cfg_pkg::NB_BLOCK_COUNTER-1:0]  o_n_idle,
    output logic [pcs_rx_cfg_pkg::NB_BLOCK_COUNTER-1:0]  o_n_term,
    output logic [pcs_rx_cfg_pkg::NB_BLOCK_COUNTER-1:0]  o_n_error
);

    pcs_format_pkg::block_kind_t kind;
    pcs_format_pkg::block_kind_t kind_q;
    logic [7:0]                  block_type;
    logic                        in_xfer;
    logic                        out_xfer;

    assign block_type = s_in.data[7:0];

    // header error wins over everything, then data, then control types
    always_comb begin
        if (s_in.sh_err) begin
            kind = pcs_format_pkg::KIND_SH_ERR;
        end else if (!s_in.ctrl) begin
            kind = pcs_format_pkg::KIND_DATA;
        end else if (block_type == pcs_format_pkg::BT_IDLE) begin
            kind = pcs_format_pkg::KIND_IDLE;
        end else if (block_type inside {pcs_format_pkg::BT_TERM_0, pcs_format_pkg::BT_TERM_1,
                                        pcs_format_pkg::BT_TERM_2, pcs_format_pkg::BT_TERM_3,
                                        pcs_format_pkg::BT_TERM_4, pcs_format_pkg::BT_TERM_5,
                                        pcs_format_pkg::BT_TERM_6, pcs_format_pkg::BT_TERM_7}) begin
            kind = pcs_format_pkg::KIND_TERM;
        end else begin
            kind = pcs_format_pkg::KIND_CTRL_OTHER;
        end
    end

    assign s_in.ready = !o_valid || i_ready;
    assign in_xfer    = s_in.valid && s_in.ready;
    assign out_xfer   = o_valid && i_ready;

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else if (s_in.ready) begin
            o_valid <= s_in.valid;
        end
    end

    always_ff @(posedge i_clock) begin
        if (in_xfer) begin
            o_data <= s_in.data;
            o_ctrl <= s_in.ctrl;
            kind_q <= kind;
        end
    end

    // count on the edge where the block leaves the lane
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_n_data  <= '0;
            o_n_idle  <= '0;
            o_n_term  <= '0;
            o_n_error <= '0;
        end else if (out_xfer) begin
            case (kind_q)
                pcs_format_pkg::KIND_DATA:   o_n_data  <= o_n_data + 1'b1;
                pcs_format_pkg::KIND_IDLE:   o_n_idle  <= o_n_idle + 1'b1;
                pcs_format_pkg::KIND_TERM:   o_n_term  <= o_n_term + 1'b1;
                pcs_format_pkg::KIND_SH_ERR: o_n_error <= o_n_error + 1'b1;
                // other control types are passed on uncounted
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* pcs_block_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface pcs_block_if;

    logic                                   valid;
    logic                                   ready;
    logic [pcs_format_pkg::NB_DATA_RAW-1:0] data;
    // header was 10
    logic                                   ctrl;
    // header was 00 or 11
    logic                                   sh_err;

    modport source (
        output valid,
        output data,
        output ctrl,
        output sh_err,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  ctrl,
        input  sh_err,
        output ready
    );

endinterface

`default_nettype wire

/* pcs_descrambler.sv */
`timescale 1ns/1ps
`default_nettype none

module pcs_descrambler (
    input  wire        i_clock,
    input  wire        i_rst_n,
    input  wire        i_bypass,

    pcs_block_if.sink   s_in,
    pcs_block_if.source m_out
);

    logic [pcs_rx_cfg_pkg::NB_SCR_STATE-1:0] scr_state;
    logic [pcs_rx_cfg_pkg::NB_SCR_STATE-1:0] scr_state_next;
    logic [pcs_format_pkg::NB_DATA_RAW-1:0]  descr_data;
    logic                                    in_xfer;

    assign s_in.ready = !m_out.valid || m_out.ready;
    assign in_xfer    = s_in.valid && s_in.ready;

    // bit 0 of the payload is the first on the line, so it goes first.
    // state bit 0 is the most recent received bit, tap n sits at index n-1
    always_comb begin
        scr_state_next = scr_state;
        for (int i = 0; i < pcs_format_pkg::NB_DATA_RAW; i++) begin
            descr_data[i] = s_in.data[i]
                          ^ scr_state_next[pcs_rx_cfg_pkg::SCR_TAP_A-1]
                          ^ scr_state_next[pcs_rx_cfg_pkg::SCR_TAP_B-1];
            // received, still scrambled bit enters the state
            scr_state_next = {scr_state_next[pcs_rx_cfg_pkg::NB_SCR_STATE-2:0], s_in.data[i]};
        end
    end

    // state tracks the line in bypass too, so leaving bypass needs no resync
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scr_state <= '0;
        end else if (in_xfer) begin
            scr_state <= scr_state_next;
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            m_out.valid <= 1'b0;
        end else if (s_in.ready) begin
            m_out.valid <= s_in.valid;
        end
    end

    always_ff @(posedge i_clock) begin
        if (in_xfer) begin
            m_out.data   <= i_bypass ? s_in.data : descr_data;
            m_out.ctrl   <= s_in.ctrl;
            m_out.sh_err <= s_in.sh_err;
        end
    end

endmodule

`default_nettype wire

/* pcs_format_pkg.sv */
`default_nettype none

package pcs_format_pkg;

    // clause 49 block layout
    localparam int NB_DATA_RAW   = 64;
    localparam int NB_SH         = 2;
    localparam int NB_DATA_CODED = NB_DATA_RAW + NB_SH;

    // sync header values, bit 0 first on the line
    localparam logic [NB_SH-1:0] SH_DATA = 2'b01;
    localparam logic [NB_SH-1:0] SH_CTRL = 2'b10;

    // control block types, payload bits 7:0
    localparam logic [7:0] BT_IDLE   = 8'h1E;
    localparam logic [7:0] BT_TERM_0 = 8'h87;
    localparam logic [7:0] BT_TERM_1 = 8'h99;
    localparam logic [7:0] BT_TERM_2 = 8'hAA;
    localparam logic [7:0] BT_TERM_3 = 8'hB4;
    localparam logic [7:0] BT_TERM_4 = 8'hCC;
    localparam logic [7:0] BT_TERM_5 = 8'hD2;
    localparam logic [7:0] BT_TERM_6 = 8'hE1;
    localparam logic [7:0] BT_TERM_7 = 8'hFF;

    // what the result stage makes of a block
    typedef enum logic [2:0] {
        KIND_DATA       = 3'd0,
        KIND_IDLE       = 3'd1,
        KIND_TERM       = 3'd2,
        KIND_CTRL_OTHER = 3'd3,
        KIND_SH_ERR     = 3'd4
    } block_kind_t;

endpackage

`default_nettype wire

/* pcs_rx_cfg_pkg.sv */
`default_nettype none

package pcs_rx_cfg_pkg;

    // self-synchronous descrambler, x^58 + x^39 + 1
    localparam int NB_SCR_STATE = 58;
    localparam int SCR_TAP_A    = 39;
    localparam int SCR_TAP_B    = 58;

    // block counters wrap at this width
    localparam int NB_BLOCK_COUNTER = 16;

endpackage

`default_nettype wire

/* pcs_rx_lane.f */
pcs_format_pkg.sv
pcs_rx_cfg_pkg.sv
pcs_block_if.sv
pcs_sh_decoder.sv
pcs_descrambler.sv
pcs_block_counter.sv
pcs_rx_lane.sv
pcs_rx_lane_asserts.sv
pcs_rx_monitor.sv
tb_pcs_rx_lane.sv

/* pcs_rx_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module pcs_rx_lane (
    input  wire                                          i_clock,
    input  wire                                          i_rst_n,

    input  wire                                          i_valid,
    output logic                                         o_ready,
    input  wire [pcs_format_pkg::NB_DATA_CODED-1:0]      i_block,

    input  wire                                          i_descrambler_bypass,

    output logic                                         o_valid,
    input  wire                                          i_ready,
    output logic [pcs_format_pkg::NB_DATA_RAW-1:0]       o_data,
    output logic                                         o_ctrl,

    output logic [pcs_rx_cfg_pkg::NB_BLOCK_COUNTER-1:0]  o_n_data,
    output logic [pcs_rx_cfg_pkg::NB_BLOCK_COUNTER-1:0]  o_n_idle,
    output logic [pcs_rx_cfg_pkg::NB_BLOCK_COUNTER-1:0]  o_n_term,
    output logic [pcs_rx_cfg_pkg::NB_BLOCK_COUNTER-1:0]  o_n_error
);

    // decode to execute, execute to result
    pcs_block_if dec_exe_if ();
    pcs_block_if exe_res_if ();

    pcs_sh_decoder u_sh_decoder (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .o_ready (o_ready),
        .i_block (i_block),
        .m_out   (dec_exe_if.source)
    );

    pcs_descrambler u_descrambler (
        .i_clock  (i_clock),
        .i_rst_n  (i_rst_n),
        .i_bypass (i_descrambler_bypass),
        .s_in     (dec_exe_if.sink),
        .m_out    (exe_res_if.source)
    );

    pcs_block_counter u_block_counter (
        .i_clock   (i_clock),
        .i_rst_n   (i_rst_n),
        .s_in      (exe_res_if.sink),
        .o_valid   (o_valid),
        .i_ready   (i_ready),
        .o_data    (o_data),
        .o_ctrl    (o_ctrl),
        .o_n_data  (o_n_data),
        .o_n_idle  (o_n_idle),
        .o_n_term  (o_n_term),
        .o_n_error (o_n_error)
    );

endmodule

`default_nettype wire

/* pcs_rx_lane_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module pcs_rx_lane_asserts (
    input wire        i_clock,
    input wire        i_rst_n,
    input wire        i_valid,
    input wire        o_ready,
    input wire [65:0] i_block,
    input wire        o_valid,
    input wire        i_ready,
    input wire [63:0] o_data,
    input wire        o_ctrl
);

    int assert_failures = 0;

    // a stalled block holds until it is taken
    assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_valid && !o_ready |=> i_valid && $stable(i_block))
    else begin
        $error("input block changed or dropped while stalled");
        assert_failures++;
    end

    assert property (@(posedge i_clock) disable iff (!i_rst_n)
        o_valid && !i_ready |=> o_valid && $stable(o_data) && $stable(o_ctrl))
    else begin
        $error("output block changed or dropped while stalled");
        assert_failures++;
    end

    assert property (@(posedge i_clock) !i_rst_n |-> !o_valid)
    else begin
        $error("o_valid high during reset");
        assert_failures++;
    end

endmodule

bind pcs_rx_lane pcs_rx_lane_asserts u_asserts (
    .i_clock (i_clock),
    .i_rst_n (i_rst_n),
    .i_valid (i_valid),
    .o_ready (o_ready),
    .i_block (i_block),
    .o_valid (o_valid),
    .i_ready (i_ready),
    .o_data  (o_data),
    .o_ctrl  (o_ctrl)
);

`default_nettype wire

/* pcs_rx_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module pcs_rx_monitor (
    input  wire         i_clock,
    input  wire         i_rst_n,
    input  wire         i_in_valid,
    input  wire         i_in_ready,
    input  wire [65:0]  i_block,
    input  wire [63:0]  i_plain,
    input  wire         i_bypass,
    input  wire         i_out_valid,
    input  wire         i_out_ready,
    input  wire [63:0]  i_data,
    input  wire         i_ctrl,
    input  wire [15:0]  i_n_data,
    input  wire [15:0]  i_n_idle,
    input  wire [15:0]  i_n_term,
    input  wire [15:0]  i_n_error,
    input  wire         i_check_end,
    output int          o_pending,
    output logic        o_done,
    output int          o_mismatches,
    output int          o_errors
);

    logic [63:0]                 exp_data_q [$];
    logic                        exp_ctrl_q [$];
    pcs_format_pkg::block_kind_t exp_kind_q [$];
    logic [57:0]                 hist;
    logic [15:0]                 cnt_data;
    logic [15:0]                 cnt_idle;
    logic [15:0]                 cnt_term;
    logic [15:0]                 cnt_error;
    logic                        stall_seen;
    logic                        reset_checked;

    // w[58 + i] is payload bit i in the 122-bit line window
    function automatic logic [63:0] ref_descramble(input logic [63:0] scr,
                                                   input logic [57:0] prev);
        logic [121:0] w;
        logic [63:0]  res;
        w = {scr, prev};
        for (int i = 0; i < 64; i++) begin
            res[i] = w[58 + i] ^ w[19 + i] ^ w[i];
        end
        return res;
    endfunction

    function automatic pcs_format_pkg::block_kind_t ref_kind(input logic [1:0] sh,
                                                             input logic [7:0] bt);
        if (sh == 2'b00 || sh == 2'b11) return pcs_format_pkg::KIND_SH_ERR;
        if (sh == 2'b01) return pcs_format_pkg::KIND_DATA;
        case (bt)
            8'h1E: return pcs_format_pkg::KIND_IDLE;
            8'h87, 8'h99, 8'hAA, 8'hB4,
            8'hCC, 8'hD2, 8'hE1, 8'hFF: return pcs_format_pkg::KIND_TERM;
            default: return pcs_format_pkg::KIND_CTRL_OTHER;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            o_mismatches++;
        end
    endtask

    always @(posedge i_clock) begin : compare
        logic [63:0]                 descr;
        logic [63:0]                 exp_data;
        logic                        exp_ctrl;
        pcs_format_pkg::block_kind_t kind;
        if (!i_rst_n) begin
            exp_data_q.delete();
            exp_ctrl_q.delete();
            exp_kind_q.delete();
            hist = '0;
            {cnt_data, cnt_idle, cnt_term, cnt_error} = '0;
            stall_seen    = 1'b0;
            reset_checked = 1'b0;
            o_mismatches  = 0;
            o_errors      = 0;
            o_done    <= 1'b0;
            o_pending <= 0;
        end else begin
            if (!reset_checked) begin
                reset_checked = 1'b1;
                compare_value("o_valid", i_out_valid, 64'h0);
                compare_value("counters", {i_n_data, i_n_idle, i_n_term, i_n_error}, 64'h0);
            end
            if (!i_in_ready) begin
                stall_seen = 1'b1;
                // a block is refused only with all three slices full and the output stalled
                if (i_out_ready || exp_data_q.size() != 3) begin
                    $display("o_ready fell while the lane was not full and stalled");
                    o_errors++;
                end
            end
            if (i_in_valid && i_in_ready) begin
                descr = ref_descramble(i_block[65:2], hist);
                hist  = i_block[65:8];
                if (!i_bypass) begin
                    compare_value("descrambled plaintext", descr, i_plain);
                end
                exp_data = i_bypass ? i_block[65:2] : descr;
                exp_data_q.push_back(exp_data);
                exp_ctrl_q.push_back(i_block[1:0] == 2'b10);
                exp_kind_q.push_back(ref_kind(i_block[1:0], exp_data[7:0]));
            end
            if (i_out_valid && i_out_ready) begin
                if (exp_data_q.size() == 0) begin
                    $display("the lane sent a block that was never put in");
                    o_errors++;
                end else begin
                    exp_data = exp_data_q.pop_front();
                    exp_ctrl = exp_ctrl_q.pop_front();
                    kind     = exp_kind_q.pop_front();
                    compare_value("o_data", i_data, exp_data);
                    compare_value("o_ctrl", i_ctrl, exp_ctrl);
                    case (kind)
                        pcs_format_pkg::KIND_DATA:   cnt_data++;
                        pcs_format_pkg::KIND_IDLE:   cnt_idle++;
                        pcs_format_pkg::KIND_TERM:   cnt_term++;
                        pcs_format_pkg::KIND_SH_ERR: cnt_error++;
                        default: ;
                    endcase
                end
            end
            if (i_check_end && !o_done) begin
                compare_value("o_n_data", i_n_data, cnt_data);
                compare_value("o_n_idle", i_n_idle, cnt_idle);
                compare_value("o_n_term", i_n_term, cnt_term);
                compare_value("o_n_error", i_n_error, cnt_error);
                if (!stall_seen) begin
                    $display("o_ready never fell while the output was stalled");
                    o_errors++;
                end
                o_done <= 1'b1;
            end
            o_pending <= exp_data_q.size();
        end
    end

endmodule

`default_nettype wire

/* pcs_sh_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module pcs_sh_decoder (
    input  wire                                       i_clock,
    input  wire                                       i_rst_n,

    input  wire                                       i_valid,
    output logic                                      o_ready,
    input  wire [pcs_format_pkg::NB_DATA_CODED-1:0]   i_block,

    pcs_block_if.source                               m_out
);

    logic [pcs_format_pkg::NB_SH-1:0]       sync_header;
    logic [pcs_format_pkg::NB_DATA_RAW-1:0] payload;
    logic                                   hdr_ctrl;
    logic                                   hdr_err;
    logic                                   in_xfer;

    // header in bits 1:0, payload above it
    assign sync_header = i_block[pcs_format_pkg::NB_SH-1:0];
    assign payload     = i_block[pcs_format_pkg::NB_DATA_CODED-1:pcs_format_pkg::NB_SH];

    assign hdr_ctrl = (sync_header == pcs_format_pkg::SH_CTRL);
    // 00 and 11 are both invalid
    assign hdr_err  = (sync_header != pcs_format_pkg::SH_DATA) &&
                      (sync_header != pcs_format_pkg::SH_CTRL);

    // slice accepts when empty or draining this cycle
    assign o_ready = !m_out.valid || m_out.ready;
    assign in_xfer = i_valid && o_ready;

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            m_out.valid <= 1'b0;
        end else if (o_ready) begin
            m_out.valid <= i_valid;
        end
    end

    always_ff @(posedge i_clock) begin
        if (in_xfer) begin
            m_out.data   <= payload;
            m_out.ctrl   <= hdr_ctrl;
            m_out.sh_err <= hdr_err;
        end
    end

endmodule

`default_nettype wire

/* tb_pcs_rx_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pcs_rx_lane;

    localparam int TIMEOUT_CYCLES = 300;

    logic        clock;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    logic [65:0] in_block;
    logic [63:0] plain;
    logic        bypass;
    logic        out_valid;
    logic        out_ready;
    logic [63:0] out_data;
    logic        out_ctrl;
    logic [15:0] n_data;
    logic [15:0] n_idle;
    logic [15:0] n_term;
    logic [15:0] n_error;
    logic        backpressure;
    logic        check_end;
    logic        done;
    int          pending;
    int          mismatches;
    int          errors;
    int          timeouts;
    logic [57:0] scr_hist;
    logic [7:0]  term_types [8] = '{8'h87, 8'h99, 8'hAA, 8'hB4, 8'hCC, 8'hD2, 8'hE1, 8'hFF};

    pcs_rx_lane dut (
        .i_clock              (clock),
        .i_rst_n              (rst_n),
        .i_valid              (in_valid),
        .o_ready              (in_ready),
        .i_block              (in_block),
        .i_descrambler_bypass (bypass),
        .o_valid              (out_valid),
        .i_ready              (out_ready),
        .o_data               (out_data),
        .o_ctrl               (out_ctrl),
        .o_n_data             (n_data),
        .o_n_idle             (n_idle),
        .o_n_term             (n_term),
        .o_n_error            (n_error)
    );

    pcs_rx_monitor u_monitor (
        .i_clock      (clock),
        .i_rst_n      (rst_n),
        .i_in_valid   (in_valid),
        .i_in_ready   (in_ready),
        .i_block      (in_block),
        .i_plain      (plain),
        .i_bypass     (bypass),
        .i_out_valid  (out_valid),
        .i_out_ready  (out_ready),
        .i_data       (out_data),
        .i_ctrl       (out_ctrl),
        .i_n_data     (n_data),
        .i_n_idle     (n_idle),
        .i_n_term     (n_term),
        .i_n_error    (n_error),
        .i_check_end  (check_end),
        .o_pending    (pending),
        .o_done       (done),
        .o_mismatches (mismatches),
        .o_errors     (errors)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // random stalls on the output only while back-pressure is on
    always @(posedge clock) begin
        out_ready <= backpressure ? (($urandom % 2) != 0) : 1'b1;
    end

    // line scrambler, x^58 + x^39 + 1, oldest bit at the bottom of the window
    function automatic logic [63:0] scramble(input logic [63:0] pt);
        logic [121:0] w;
        w = '0;
        w[57:0] = scr_hist;
        for (int i = 0; i < 64; i++) begin
            w[58 + i] = pt[i] ^ w[19 + i] ^ w[i];
        end
        scr_hist = w[121:64];
        return w[121:58];
    endfunction

    task automatic send_block(input logic [65:0] blk, input logic [63:0] pt);
        int n;
        if (timeouts == 0) begin
            in_valid <= 1'b1;
            in_block <= blk;
            plain    <= pt;
            n = 0;
            @(posedge clock);
            while (!in_ready && n < TIMEOUT_CYCLES) begin
                @(posedge clock);
                n++;
            end
            if (!in_ready) begin
                $display("timeout: the lane did not accept a block within %0d cycles",
                         TIMEOUT_CYCLES);
                timeouts++;
            end
        end
    endtask

    task automatic send_random_block();
        logic [63:0] pt;
        logic [1:0]  sh;
        pt = {$urandom, $urandom};
        sh = 2'b10;
        case ($urandom % 5)
            0: sh = 2'b01;
            1: pt[7:0] = 8'h1E;
            2: pt[7:0] = term_types[$urandom % 8];
            // ordered set, a control type that is not counted
            3: pt[7:0] = 8'h4B;
            default: sh = (($urandom % 2) != 0) ? 2'b11 : 2'b00;
        endcase
        send_block({scramble(pt), sh}, pt);
    endtask

    task automatic stop_and_drain();
        int n;
        in_valid <= 1'b0;
        if (timeouts == 0) begin
            n = 0;
            @(posedge clock);
            while (pending != 0 && n < TIMEOUT_CYCLES) begin
                @(posedge clock);
                n++;
            end
            if (pending != 0) begin
                $display("timeout: %0d blocks never left the lane", pending);
                timeouts++;
            end
        end
    endtask

    initial begin : main
        int n;
        void'($urandom(32'h7ea4));
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_block     = '0;
        plain        = '0;
        bypass       = 1'b0;
        out_ready    = 1'b1;
        backpressure = 1'b0;
        check_end    = 1'b0;
        timeouts     = 0;
        scr_hist     = '0;
        repeat (16) @(posedge clock);
        rst_n <= 1'b1;
        repeat (60) send_random_block();
        stop_and_drain();
        backpressure <= 1'b1;
        repeat (80) send_random_block();
        stop_and_drain();
        backpressure <= 1'b0;
        bypass       <= 1'b1;
        repeat (30) send_random_block();
        stop_and_drain();
        // scrambler keeps running, the descrambler state must still be in step
        bypass <= 1'b0;
        repeat (30) send_random_block();
        stop_and_drain();
        check_end <= 1'b1;
        n = 0;
        @(posedge clock);
        while (!done && n < TIMEOUT_CYCLES) begin
            @(posedge clock);
            n++;
        end
        if (!done) begin
            $display("timeout: the final counter check never ran");
            timeouts++;
        end
        $display("checks done: %0d mismatches, %0d other errors, %0d assertion failures, %0d timeouts",
                 mismatches, errors, dut.u_asserts.assert_failures, timeouts);
        if (mismatches == 0 && errors == 0 && timeouts == 0 &&
            dut.u_asserts.assert_failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
